// ==== mul_apb_regs.sv ====
`include "mul_settings.svh"

module mul_apb_regs
    import mul_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    input  logic                   ready,
    input  logic                   valid,
    input  mul_product_u           product,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   irq,
    output logic                   start,
    output logic                   is_signed,
    output logic [`MUL_WIDTH-1:0]  multiplicand,
    output logic [`MUL_WIDTH-1:0]  multiplier
);

    logic access;
    logic busy;
    logic mapped;
    logic operand_addr;
    logic wr_ok;
    logic rd_ok;
    logic done;

    assign access = psel && penable;
    assign busy   = !ready;

    always_comb begin
        case (paddr)
            `MUL_ADDR_A, `MUL_ADDR_B, `MUL_ADDR_CTRL,
            `MUL_ADDR_STATUS, `MUL_ADDR_PROD_LO, `MUL_ADDR_PROD_HI: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    // registers that must not move while the core runs.
    assign operand_addr = (paddr == `MUL_ADDR_A) || (paddr == `MUL_ADDR_B) ||
                          (paddr == `MUL_ADDR_CTRL);

    assign pslverr = access && (!mapped || (pwrite && operand_addr && busy));
    assign pready  = 1'b1;

    assign wr_ok = access && pwrite && !pslverr;
    assign rd_ok = access && !pwrite && !pslverr;

    // operand registers.
    always_ff @(posedge clk) begin
        if (wr_ok && paddr == `MUL_ADDR_A) begin
            multiplicand <= pwdata;
        end
        if (wr_ok && paddr == `MUL_ADDR_B) begin
            multiplier <= pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            start     <= 1'b0;
            is_signed <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_ok && paddr == `MUL_ADDR_CTRL) begin
                is_signed <= pwdata[1];
                start     <= pwdata[0] && ready;
            end
        end
    end

    // sticky completion flag that a status read or a new start clears.
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (valid) begin
            done <= 1'b1;
        end else if (start || (rd_ok && paddr == `MUL_ADDR_STATUS)) begin
            done <= 1'b0;
        end
    end

    assign irq = done;

    always_comb begin
        prdata = '0;
        if (rd_ok) begin
            case (paddr)
                `MUL_ADDR_A:       prdata = multiplicand;
                `MUL_ADDR_B:       prdata = multiplier;
                `MUL_ADDR_CTRL:    prdata = {30'b0, is_signed, 1'b0};
                `MUL_ADDR_STATUS:  prdata = {30'b0, done, busy};
                `MUL_ADDR_PROD_LO: prdata = product.halves.lo;
                `MUL_ADDR_PROD_HI: prdata = product.halves.hi;
                default:           prdata = '0;
            endcase
        end
    end

endmodule

// ==== mul_apb_top.sv ====
`include "mul_settings.svh"

module mul_apb_top
    import mul_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        irq
);

    logic                  start;
    logic                  is_signed;
    logic [`MUL_WIDTH-1:0] multiplicand;
    logic [`MUL_WIDTH-1:0] multiplier;
    logic                  ready;
    logic                  valid;
    mul_product_u          product;

    mul_apb_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .ready        (ready),
        .valid        (valid),
        .product      (product),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .irq          (irq),
        .start        (start),
        .is_signed    (is_signed),
        .multiplicand (multiplicand),
        .multiplier   (multiplier)
    );

    mul_signed u_mul (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .is_signed    (is_signed),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .ready        (ready),
        .valid        (valid),
        .product      (product)
    );

endmodule

// ==== mul_asserts.sv ====
`include "mul_settings.svh"

module mul_asserts (
    input logic        clk,
    input logic        reset,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [7:0]  paddr,
    input logic [31:0] pwdata,
    input logic        pready,
    input logic        pslverr,
    input logic        irq,
    input logic        start,
    input logic        ready
);

    int fail_count = 0;

    logic access;
    logic start_write;
    logic status_read;

    assign access = psel && penable;

    // accepted control write that launches a multiply.
    assign start_write = access && pwrite && !pslverr && (paddr == `MUL_ADDR_CTRL) &&
                         pwdata[0] && ready;
    assign status_read = access && !pwrite && (paddr == `MUL_ADDR_STATUS);

    pready_high: assert property (@(posedge clk) disable iff (reset) pready) else begin
        fail_count++;
        $error("pready went low");
    end

    slverr_in_access: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> access) else begin
        fail_count++;
        $error("pslverr was high outside an access phase");
    end

    // irq rises on the 35th edge after the write.
    irq_latency: assert property (@(posedge clk) disable iff (reset)
        start_write |-> ##35 (!irq ##1 irq)) else begin
        fail_count++;
        $error("irq did not rise 35 cycles after the start write");
    end

    irq_held: assert property (@(posedge clk) disable iff (reset)
        irq && !status_read && !start |=> irq) else begin
        fail_count++;
        $error("irq dropped before a status read");
    end

    irq_cleared: assert property (@(posedge clk) disable iff (reset)
        irq && status_read |=> !irq) else begin
        fail_count++;
        $error("irq stayed high after a status read");
    end

endmodule

bind mul_apb_top mul_asserts u_asserts (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pready  (pready),
    .pslverr (pslverr),
    .irq     (irq),
    .start   (start),
    .ready   (ready)
);

// ==== mul_bit_counter.sv ====
`include "mul_settings.svh"

module mul_bit_counter (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  logic step,
    output logic last
);

    logic [`MUL_CNT_WIDTH-1:0] count;

    // counts down the remaining steps.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= `MUL_CNT_WIDTH'(`MUL_WIDTH);
        end else if (step && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // one step left means this is the final one.
    assign last = (count == `MUL_CNT_WIDTH'(1));

endmodule

// ==== mul_ctrl_fsm.sv ====
module mul_ctrl_fsm
    import mul_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic last,
    output logic load,
    output logic step,
    output logic ready,
    output logic valid
);

    mul_core_state_e state;

    // load is registered, so it fills the first run cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_idle;
            load  <= 1'b0;
        end else begin
            load <= 1'b0;
            case (state)
                core_idle: begin
                    if (start) begin
                        state <= core_run;
                        load  <= 1'b1;
                    end
                end
                core_run: begin
                    if (last) begin
                        state <= core_finish;
                    end
                end
                core_finish: begin
                    state <= core_idle;
                end
                default: begin
                    state <= core_idle;
                end
            endcase
        end
    end

    // one add-and-shift per run cycle after the load.
    assign step = (state == core_run) && !load;

    assign ready = (state != core_run);
    assign valid = (state == core_finish);

endmodule

// ==== mul_pkg.sv ====
`include "mul_settings.svh"

package mul_pkg;

    // the datapath writes the full word, the register block reads halves.
    typedef union packed {
        logic [2*`MUL_WIDTH-1:0] full;
        struct packed {
            logic [`MUL_WIDTH-1:0] hi;
            logic [`MUL_WIDTH-1:0] lo;
        } halves;
    } mul_product_u;

    // unsigned core sequencing.
    typedef enum logic [1:0] {
        core_idle,
        core_run,
        core_finish
    } mul_core_state_e;

    // signed wrapper, waits for the core between start and valid.
    typedef enum logic {
        sign_idle,
        sign_wait
    } mul_sign_state_e;

endpackage

// ==== mul_settings.svh ====
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// operand width, fixed by the apb data width.
`define MUL_WIDTH 32

// wide enough to hold the step count.
`define MUL_CNT_WIDTH 6

// register byte offsets.
`define MUL_ADDR_A       8'h00
`define MUL_ADDR_B       8'h04
`define MUL_ADDR_CTRL    8'h08
`define MUL_ADDR_STATUS  8'h0C
`define MUL_ADDR_PROD_LO 8'h10
`define MUL_ADDR_PROD_HI 8'h14

`endif

// ==== mul_shift_add_datapath.sv ====
`include "mul_settings.svh"

module mul_shift_add_datapath
    import mul_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   step,
    input  logic [`MUL_WIDTH-1:0]  multiplicand,
    input  logic [`MUL_WIDTH-1:0]  multiplier,
    output mul_product_u           product
);

    logic [`MUL_WIDTH-1:0] mcand;
    logic [`MUL_WIDTH-1:0] acc;
    logic [`MUL_WIDTH-1:0] mplr;
    logic [`MUL_WIDTH:0]   sum;

    // carry out lands in the top of the shifted accumulator.
    assign sum = {1'b0, acc} + {1'b0, (mplr[0] ? mcand : `MUL_WIDTH'(0))};

    always_ff @(posedge clk) begin
        if (load) begin
            mcand <= multiplicand;
        end
    end

    // acc and mplr form one register, low bits shift out as they are used.
    always_ff @(posedge clk) begin
        if (reset) begin
            acc  <= '0;
            mplr <= '0;
        end else if (load) begin
            acc  <= '0;
            mplr <= multiplier;
        end else if (step) begin
            acc  <= sum[`MUL_WIDTH:1];
            mplr <= {sum[0], mplr[`MUL_WIDTH-1:1]};
        end
    end

    assign product.full = {acc, mplr};

endmodule

// ==== mul_signed.sv ====
`include "mul_settings.svh"

module mul_signed
    import mul_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   is_signed,
    input  logic [`MUL_WIDTH-1:0]  multiplicand,
    input  logic [`MUL_WIDTH-1:0]  multiplier,
    output logic                   ready,
    output logic                   valid,
    output mul_product_u           product
);

    mul_sign_state_e state;

    logic                  result_neg;
    logic                  a_neg;
    logic                  b_neg;
    logic [`MUL_WIDTH-1:0] mag_a;
    logic [`MUL_WIDTH-1:0] mag_b;
    mul_product_u          core_product;

    assign a_neg = is_signed && multiplicand[`MUL_WIDTH-1];
    assign b_neg = is_signed && multiplier[`MUL_WIDTH-1];

    // the most negative value maps to its own bit pattern, read as unsigned.
    assign mag_a = a_neg ? (`MUL_WIDTH'(0) - multiplicand) : multiplicand;
    assign mag_b = b_neg ? (`MUL_WIDTH'(0) - multiplier) : multiplier;

    mul_unsigned u_core (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .multiplicand (mag_a),
        .multiplier   (mag_b),
        .ready        (ready),
        .valid        (valid),
        .product      (core_product)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= sign_idle;
            result_neg <= 1'b0;
        end else begin
            case (state)
                sign_idle: begin
                    if (start) begin
                        state      <= sign_wait;
                        result_neg <= a_neg ^ b_neg;
                    end
                end
                sign_wait: begin
                    if (valid) begin
                        state <= sign_idle;
                    end
                end
                default: state <= sign_idle;
            endcase
        end
    end

    // two's complement of the magnitude product.
    assign product.full = result_neg ? ((2*`MUL_WIDTH)'(0) - core_product.full)
                                     : core_product.full;

endmodule

// ==== mul_tb.sv ====
`include "mul_settings.svh"

module mul_tb;

    // 40 operations of 45 cycles plus a margin.
    localparam int MAX_CYCLES = 40 * 45 + 500;

    logic        clk = 1'b0;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;

    integer seed = 32'h3274b47d;
    int     errors = 0;
    int     cycles = 0;

    mul_apb_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // setup, access, then back to idle.
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_word("pslverr", exp_err, err);
    endtask

    task automatic read_check(input string name, input logic [7:0] addr,
                              input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rdata, err);
        check_word("pslverr", 32'h0, err);
        check_word(name, expected, rdata);
    endtask

    task automatic wait_irq();
        int n = 0;
        while (!irq && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            errors++;
            $display("irq did not rise within %0d cycles of the start", n);
        end
    endtask

    // zero or sign extension, then one wide multiply.
    function automatic logic [63:0] expected_product(input logic [31:0] a,
                                                     input logic [31:0] b,
                                                     input logic is_signed);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = is_signed ? {{32{a[31]}}, a} : {32'h0, a};
        sb = is_signed ? {{32{b[31]}}, b} : {32'h0, b};
        return sa * sb;
    endfunction

    task automatic run_multiply(input logic [31:0] a, input logic [31:0] b,
                                input logic is_signed);
        logic [63:0] expected;
        expected = expected_product(a, b, is_signed);
        write_reg(`MUL_ADDR_A, a, 1'b0);
        write_reg(`MUL_ADDR_B, b, 1'b0);
        write_reg(`MUL_ADDR_CTRL, {30'h0, is_signed, 1'b1}, 1'b0);
        wait_irq();
        read_check("status", `MUL_ADDR_STATUS, 32'h2);
        check_word("irq", 32'h0, irq);
        read_check("prod_lo", `MUL_ADDR_PROD_LO, expected[31:0]);
        read_check("prod_hi", `MUL_ADDR_PROD_HI, expected[63:32]);
    endtask

    // writes while the core runs must bounce and leave everything intact.
    task automatic busy_writes();
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] expected;
        a = $random(seed);
        b = $random(seed);
        expected = expected_product(a, b, 1'b0);
        write_reg(`MUL_ADDR_A, a, 1'b0);
        write_reg(`MUL_ADDR_B, b, 1'b0);
        write_reg(`MUL_ADDR_CTRL, 32'h1, 1'b0);
        read_check("status", `MUL_ADDR_STATUS, 32'h1);
        write_reg(`MUL_ADDR_A, ~a, 1'b1);
        write_reg(`MUL_ADDR_CTRL, 32'h3, 1'b1);
        read_check("a", `MUL_ADDR_A, a);
        read_check("b", `MUL_ADDR_B, b);
        read_check("ctrl", `MUL_ADDR_CTRL, 32'h0);
        wait_irq();
        read_check("status", `MUL_ADDR_STATUS, 32'h2);
        read_check("prod_lo", `MUL_ADDR_PROD_LO, expected[31:0]);
        read_check("prod_hi", `MUL_ADDR_PROD_HI, expected[63:32]);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        int          total;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h0;
        pwdata  = 32'h0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        check_word("irq", 32'h0, irq);
        check_word("pslverr", 32'h0, pslverr);
        read_check("status", `MUL_ADDR_STATUS, 32'h0);
        read_check("prod_lo", `MUL_ADDR_PROD_LO, 32'h0);
        read_check("prod_hi", `MUL_ADDR_PROD_HI, 32'h0);

        run_multiply(32'h0, 32'h0, 1'b0);
        run_multiply(32'h0, 32'hffff_ffff, 1'b0);
        run_multiply(32'hffff_ffff, 32'hffff_ffff, 1'b0);
        run_multiply(32'hffff_ffff, 32'h1, 1'b0);
        repeat (12) begin
            a = $random(seed);
            b = $random(seed);
            run_multiply(a, b, 1'b0);
        end

        // all sign pairs, then the most negative value.
        run_multiply(32'd1234567, 32'd7654321, 1'b1);
        run_multiply(32'd1234567, -32'd7654321, 1'b1);
        run_multiply(-32'd1234567, 32'd7654321, 1'b1);
        run_multiply(-32'd1234567, -32'd7654321, 1'b1);
        run_multiply(32'h8000_0000, 32'hffff_ffff, 1'b1);
        run_multiply(32'h8000_0000, 32'h8000_0000, 1'b1);
        repeat (8) begin
            a = $random(seed);
            b = $random(seed);
            run_multiply(a, b, 1'b1);
        end

        write_reg(8'h20, 32'h5, 1'b1);
        busy_writes();

        repeat (5) @(negedge clk);
        total = errors + u_dut.u_asserts.fail_count;
        $display("errors: %0d in the testbench, %0d in the assertions",
                 errors, u_dut.u_asserts.fail_count);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== mul_unsigned.sv ====
`include "mul_settings.svh"

module mul_unsigned
    import mul_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic [`MUL_WIDTH-1:0]  multiplicand,
    input  logic [`MUL_WIDTH-1:0]  multiplier,
    output logic                   ready,
    output logic                   valid,
    output mul_product_u           product
);

    logic load;
    logic step;
    logic last;

    mul_ctrl_fsm u_fsm (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .last  (last),
        .load  (load),
        .step  (step),
        .ready (ready),
        .valid (valid)
    );

    mul_bit_counter u_counter (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .step  (step),
        .last  (last)
    );

    mul_shift_add_datapath u_datapath (
        .clk          (clk),
        .reset        (reset),
        .load         (load),
        .step         (step),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product)
    );

endmodule

// ==== tb.f ====
+incdir+.
mul_pkg.sv
mul_bit_counter.sv
mul_ctrl_fsm.sv
mul_shift_add_datapath.sv
mul_unsigned.sv
mul_signed.sv
mul_apb_regs.sv
mul_apb_top.sv
mul_asserts.sv
mul_tb.sv
